/* Bender.yml */
package:
  name: segre_core

sources:
  - files:
      - segre_pkg.sv
      - segre_mem_if.sv
      - segre_register_file.sv
      - segre_if_stage.sv
      - segre_id_stage.sv
      - segre_ex_stage.sv
      - segre_mmu.sv
      - segre_core.sv
  - target: test
    files:
      - segre_core_properties.sv
      - tb_segre_core.sv

/* build.f */
segre_pkg.sv
segre_mem_if.sv
segre_register_file.sv
segre_if_stage.sv
segre_id_stage.sv
segre_ex_stage.sv
segre_mmu.sv
segre_core.sv
segre_core_properties.sv
tb_segre_core.sv

/* segre_core.sv */
module segre_core #(
    parameter logic [segre_pkg::ADDR_SIZE-1:0] BOOT_ADDR = '0
) (
    // Clock and Reset
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Main memory
    input  logic                            mm_data_rdy_i,
    input  logic [segre_pkg::XLEN-1:0]      mm_rd_data_i,
    output logic [segre_pkg::XLEN-1:0]      mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic                            mm_rd_o,
    output logic                            mm_wr_o
);

logic [31:0]                         instr;
logic [segre_pkg::ADDR_SIZE-1:0]     pc;
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a;
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b;
logic [segre_pkg::XLEN-1:0]          rf_data_a;
logic [segre_pkg::XLEN-1:0]          rf_data_b;
segre_pkg::decoded_t                 decoded;
logic                                exec_start;
logic                                exec_done;
logic                                taken;
logic [segre_pkg::ADDR_SIZE-1:0]     new_pc;
logic                                rf_we;
logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr;
logic [segre_pkg::XLEN-1:0]          rf_wdata;

// Instruction and data channels into the MMU
segre_mem_if ic_ch ();
segre_mem_if dc_ch ();

segre_if_stage #(
    .BOOT_ADDR (BOOT_ADDR)
) if_stage (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ic_ch        (ic_ch),
    .exec_done_i  (exec_done),
    .taken_i      (taken),
    .new_pc_i     (new_pc),
    .instr_o      (instr),
    .pc_o         (pc),
    .exec_start_o (exec_start)
);

segre_id_stage id_stage (
    .instr_i      (instr),
    .pc_i         (pc),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_data_a_i  (rf_data_a),
    .rf_data_b_i  (rf_data_b),
    .decoded_o    (decoded)
);

segre_ex_stage ex_stage (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .decoded_i    (decoded),
    .exec_start_i (exec_start),
    .dc_ch        (dc_ch),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .exec_done_o  (exec_done),
    .taken_o      (taken),
    .new_pc_o     (new_pc)
);

segre_register_file segre_rf (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .data_a_o  (rf_data_a),
    .data_b_o  (rf_data_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
);

segre_mmu mmu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ic_ch         (ic_ch),
    .dc_ch         (dc_ch),
    .mm_data_rdy_i (mm_data_rdy_i),
    .mm_rd_data_i  (mm_rd_data_i),
    .mm_wr_data_o  (mm_wr_data_o),
    .mm_addr_o     (mm_addr_o),
    .mm_wr_addr_o  (mm_wr_addr_o),
    .mm_rd_o       (mm_rd_o),
    .mm_wr_o       (mm_wr_o)
);

endmodule : segre_core

/* segre_core_properties.sv */
module segre_core_properties (
    input logic                            clk_i,
    input logic                            arst_n_i,
    input logic                            mm_rd_i,
    input logic                            mm_wr_i,
    input logic [segre_pkg::ADDR_SIZE-1:0] mm_addr_i,
    input logic [segre_pkg::ADDR_SIZE-1:0] mm_wr_addr_i,
    input logic [segre_pkg::XLEN-1:0]      mm_wr_data_i,
    input logic                            mm_data_rdy_i
);
timeunit 1ns;
timeprecision 1ps;

// Number of failed properties so far
int unsigned fail_count = 0;

rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(mm_rd_i && mm_wr_i))
    else begin
        fail_count++;
        $error("mm_rd_o and mm_wr_o are high in the same cycle");
    end

// A pending request holds its kind, address and data until rdy
request_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((mm_rd_i || mm_wr_i) && !mm_data_rdy_i) |=>
        ($stable(mm_rd_i) && $stable(mm_wr_i) && $stable(mm_addr_i) &&
         $stable(mm_wr_addr_i) && $stable(mm_wr_data_i)))
    else begin
        fail_count++;
        $error("main-memory request changed before mm_data_rdy_i");
    end

idle_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!mm_rd_i && !mm_wr_i))
    else begin
        fail_count++;
        $error("main-memory request raised while arst_n_i is low");
    end

endmodule : segre_core_properties

bind segre_core segre_core_properties i_segre_core_properties (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .mm_rd_i       (mm_rd_o),
    .mm_wr_i       (mm_wr_o),
    .mm_addr_i     (mm_addr_o),
    .mm_wr_addr_i  (mm_wr_addr_o),
    .mm_wr_data_i  (mm_wr_data_o),
    .mm_data_rdy_i (mm_data_rdy_i)
);

/* segre_ex_stage.sv */
module segre_ex_stage (
    // Clock and Reset
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // From ID and IF
    input  segre_pkg::decoded_t                 decoded_i,
    input  logic                                exec_start_i,
    // Data channel to the MMU
    segre_mem_if.requester                      dc_ch,
    // Register file write port
    output logic                                rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o,
    output logic [segre_pkg::XLEN-1:0]          rf_wdata_o,
    // Completion to IF
    output logic                                exec_done_o,
    output logic                                taken_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]     new_pc_o
);

typedef enum logic [1:0] {
    IDLE,
    EXEC,
    DONE
} ex_state_e;

ex_state_e                  state_q;
segre_pkg::decoded_t        dec_q;
logic [segre_pkg::XLEN-1:0] alu_res;
logic [segre_pkg::XLEN-1:0] load_q;
logic                       is_mem;
logic                       ops_eq;

assign is_mem = dec_q.memop_rd | dec_q.memop_wr;
assign ops_eq = (dec_q.op_a == dec_q.op_b);

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        state_q <= IDLE;
    end else begin
        case (state_q)
            IDLE:    state_q <= exec_start_i ? EXEC : IDLE;
            // Memory ops stay here until the data rdy
            EXEC:    state_q <= !is_mem ? IDLE : (dc_ch.rdy ? DONE : EXEC);
            default: state_q <= IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (exec_start_i) begin
        dec_q <= decoded_i;
    end
    if (state_q == EXEC && dc_ch.rdy) begin
        load_q <= dc_ch.rdata;
    end
end

always_comb begin
    case (dec_q.alu_op)
        segre_pkg::ALU_SUB:    alu_res = dec_q.op_a - dec_q.op_b;
        segre_pkg::ALU_AND:    alu_res = dec_q.op_a & dec_q.op_b;
        segre_pkg::ALU_OR:     alu_res = dec_q.op_a | dec_q.op_b;
        segre_pkg::ALU_XOR:    alu_res = dec_q.op_a ^ dec_q.op_b;
        segre_pkg::ALU_PASS_B: alu_res = dec_q.op_b;
        default:               alu_res = dec_q.op_a + dec_q.op_b;
    endcase
end

// Word aligned data access
assign dc_ch.req   = (state_q == EXEC) && is_mem;
assign dc_ch.we    = dec_q.memop_wr;
assign dc_ch.addr  = {alu_res[segre_pkg::ADDR_SIZE-1:2], 2'b00};
assign dc_ch.wdata = dec_q.st_data;

assign exec_done_o = ((state_q == EXEC) && !is_mem) || (state_q == DONE);
assign rf_we_o     = exec_done_o && dec_q.rf_we;
assign rf_waddr_o  = dec_q.rf_waddr;
assign rf_wdata_o  = dec_q.memop_rd ? load_q : alu_res;

assign taken_o  = (dec_q.br_eq && ops_eq) || (dec_q.br_ne && !ops_eq);
assign new_pc_o = dec_q.br_target;

endmodule : segre_ex_stage

/* segre_id_stage.sv */
module segre_id_stage (
    // From IF
    input  logic [31:0]                         instr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]     pc_i,
    // Register file read ports
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b_o,
    input  logic [segre_pkg::XLEN-1:0]          rf_data_a_i,
    input  logic [segre_pkg::XLEN-1:0]          rf_data_b_i,
    // To EX
    output segre_pkg::decoded_t                 decoded_o
);

logic [segre_pkg::REG_ADDR_SIZE-1:0] rd;
logic [2:0]                          funct3;
logic [segre_pkg::XLEN-1:0]          imm_i;
logic [segre_pkg::XLEN-1:0]          imm_s;
logic [segre_pkg::XLEN-1:0]          imm_b;
logic [segre_pkg::XLEN-1:0]          imm_u;

assign rd     = instr_i[11:7];
assign funct3 = instr_i[14:12];

assign rf_raddr_a_o = instr_i[19:15];
assign rf_raddr_b_o = instr_i[24:20];

// Sign-extended immediates
assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                instr_i[11:8], 1'b0};
assign imm_u = {instr_i[31:12], 12'b0};

always_comb begin
    // Anything not matched below leaves a no-op
    decoded_o.alu_op    = segre_pkg::ALU_ADD;
    decoded_o.op_a      = rf_data_a_i;
    decoded_o.op_b      = rf_data_b_i;
    decoded_o.rf_we     = 1'b0;
    decoded_o.rf_waddr  = rd;
    decoded_o.memop_rd  = 1'b0;
    decoded_o.memop_wr  = 1'b0;
    decoded_o.st_data   = rf_data_b_i;
    decoded_o.br_eq     = 1'b0;
    decoded_o.br_ne     = 1'b0;
    decoded_o.br_target = pc_i + imm_b;

    case (segre_pkg::opcode_e'(instr_i[6:0]))
        segre_pkg::OPCODE_LUI: begin
            decoded_o.alu_op = segre_pkg::ALU_PASS_B;
            decoded_o.op_a   = '0;
            decoded_o.op_b   = imm_u;
            decoded_o.rf_we  = 1'b1;
        end
        segre_pkg::OPCODE_OP_IMM: begin
            // Only ADDI
            decoded_o.op_b  = imm_i;
            decoded_o.rf_we = (funct3 == 3'b000);
        end
        segre_pkg::OPCODE_OP: begin
            decoded_o.rf_we = 1'b1;
            case (funct3)
                // Bit 30 is funct7[5] and selects SUB
                3'b000:  decoded_o.alu_op = instr_i[30] ? segre_pkg::ALU_SUB
                                                        : segre_pkg::ALU_ADD;
                3'b100:  decoded_o.alu_op = segre_pkg::ALU_XOR;
                3'b110:  decoded_o.alu_op = segre_pkg::ALU_OR;
                3'b111:  decoded_o.alu_op = segre_pkg::ALU_AND;
                default: decoded_o.rf_we  = 1'b0;
            endcase
        end
        segre_pkg::OPCODE_LOAD: begin
            decoded_o.op_b     = imm_i;
            decoded_o.rf_we    = (funct3 == 3'b010);
            decoded_o.memop_rd = (funct3 == 3'b010);
        end
        segre_pkg::OPCODE_STORE: begin
            decoded_o.op_b     = imm_s;
            decoded_o.memop_wr = (funct3 == 3'b010);
        end
        segre_pkg::OPCODE_BRANCH: begin
            decoded_o.br_eq = (funct3 == 3'b000);
            decoded_o.br_ne = (funct3 == 3'b001);
        end
        default: begin
        end
    endcase
end

endmodule : segre_id_stage

/* segre_if_stage.sv */
module segre_if_stage #(
    parameter logic [segre_pkg::ADDR_SIZE-1:0] BOOT_ADDR = '0
) (
    // Clock and Reset
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Instruction channel to the MMU
    segre_mem_if.requester                  ic_ch,
    // Completion from EX
    input  logic                            exec_done_i,
    input  logic                            taken_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] new_pc_i,
    // To ID and EX
    output logic [31:0]                     instr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] pc_o,
    output logic                            exec_start_o
);

// NEXT is only seen out of reset, before the first fetch
typedef enum logic [1:0] {
    NEXT,
    FETCH,
    WAIT_EXEC
} if_state_e;

if_state_e                       state_q;
logic [segre_pkg::ADDR_SIZE-1:0] pc_q;
logic [31:0]                     instr_q;
logic                            start_q;

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        state_q <= NEXT;
        pc_q    <= BOOT_ADDR;
        start_q <= 1'b0;
    end else begin
        start_q <= 1'b0;
        case (state_q)
            NEXT: begin
                state_q <= FETCH;
            end
            FETCH: begin
                if (ic_ch.rdy) begin
                    state_q <= WAIT_EXEC;
                    start_q <= 1'b1;
                end
            end
            WAIT_EXEC: begin
                // PC moves on only once EX has finished
                if (exec_done_i) begin
                    state_q <= FETCH;
                    pc_q    <= taken_i ? new_pc_i : pc_q + segre_pkg::ADDR_SIZE'(4);
                end
            end
            default: begin
                state_q <= NEXT;
            end
        endcase
    end
end

// Instruction register
always_ff @(posedge clk_i) begin
    if (state_q == FETCH && ic_ch.rdy) begin
        instr_q <= ic_ch.rdata;
    end
end

assign ic_ch.req   = (state_q == FETCH);
assign ic_ch.we    = 1'b0;
assign ic_ch.addr  = pc_q;
assign ic_ch.wdata = '0;

assign instr_o      = instr_q;
assign pc_o         = pc_q;
assign exec_start_o = start_q;

endmodule : segre_if_stage

/* segre_mem_if.sv */
interface segre_mem_if;

    logic                             req;
    logic                             we;
    logic [segre_pkg::ADDR_SIZE-1:0]  addr;
    logic [segre_pkg::XLEN-1:0]       wdata;
    logic [segre_pkg::XLEN-1:0]       rdata;
    logic                             rdy;

    // Stage side, holds the request until rdy
    modport requester (
        output req, we, addr, wdata,
        input  rdata, rdy
    );

    // MMU side
    modport server (
        input  req, we, addr, wdata,
        output rdata, rdy
    );

endinterface : segre_mem_if

/* segre_mmu.sv */
module segre_mmu (
    // Clock and Reset
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Stage channels
    segre_mem_if.server                     ic_ch,
    segre_mem_if.server                     dc_ch,
    // Main memory
    input  logic                            mm_data_rdy_i,
    input  logic [segre_pkg::XLEN-1:0]      mm_rd_data_i,
    output logic [segre_pkg::XLEN-1:0]      mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic                            mm_rd_o,
    output logic                            mm_wr_o
);

typedef enum logic [1:0] {
    GNT_NONE,
    GNT_IC,
    GNT_DC
} grant_e;

grant_e                          grant_q;
logic                            sel_ic;
logic                            sel_dc;
logic                            act_req;
logic                            act_we;
logic [segre_pkg::ADDR_SIZE-1:0] act_addr;
logic [segre_pkg::XLEN-1:0]      act_wdata;

// Held grant first, otherwise data beats instruction
assign sel_dc = (grant_q == GNT_DC) || (grant_q == GNT_NONE && dc_ch.req);
assign sel_ic = (grant_q == GNT_IC) || (grant_q == GNT_NONE && !dc_ch.req && ic_ch.req);

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        grant_q <= GNT_NONE;
    end else if (mm_data_rdy_i) begin
        grant_q <= GNT_NONE;
    end else if (grant_q == GNT_NONE) begin
        grant_q <= sel_dc ? GNT_DC : (sel_ic ? GNT_IC : GNT_NONE);
    end
end

always_comb begin
    act_req   = 1'b0;
    act_we    = 1'b0;
    act_addr  = '0;
    act_wdata = '0;
    if (sel_dc) begin
        act_req   = dc_ch.req;
        act_we    = dc_ch.we;
        act_addr  = dc_ch.addr;
        act_wdata = dc_ch.wdata;
    end else if (sel_ic) begin
        act_req   = ic_ch.req;
        act_we    = ic_ch.we;
        act_addr  = ic_ch.addr;
        act_wdata = ic_ch.wdata;
    end
end

assign mm_rd_o      = act_req && !act_we;
assign mm_wr_o      = act_req && act_we;
// Reads use mm_addr_o, writes the separate write address
assign mm_addr_o    = act_we ? '0 : act_addr;
assign mm_wr_addr_o = act_we ? act_addr : '0;
assign mm_wr_data_o = act_wdata;

assign ic_ch.rdy   = sel_ic && mm_data_rdy_i;
assign dc_ch.rdy   = sel_dc && mm_data_rdy_i;
assign ic_ch.rdata = mm_rd_data_i;
assign dc_ch.rdata = mm_rd_data_i;

endmodule : segre_mmu

/* segre_pkg.sv */
package segre_pkg;

    localparam int XLEN          = 32;
    localparam int ADDR_SIZE     = 32;
    localparam int REG_ADDR_SIZE = 5;

    // RISC-V major opcodes handled by the core
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // Decoded instruction handed from ID to EX
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [XLEN-1:0]          op_a;
        logic [XLEN-1:0]          op_b;
        logic                     rf_we;
        logic [REG_ADDR_SIZE-1:0] rf_waddr;
        logic                     memop_rd;
        logic                     memop_wr;
        logic [XLEN-1:0]          st_data;
        logic                     br_eq;
        logic                     br_ne;
        logic [ADDR_SIZE-1:0]     br_target;
    } decoded_t;

endpackage : segre_pkg

/* segre_register_file.sv */
module segre_register_file (
    // Clock and Reset
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // Read ports
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_a_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_b_i,
    output logic [segre_pkg::XLEN-1:0]          data_a_o,
    output logic [segre_pkg::XLEN-1:0]          data_b_o,
    // Write port
    input  logic                                we_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] waddr_i,
    input  logic [segre_pkg::XLEN-1:0]          wdata_i
);

logic [segre_pkg::XLEN-1:0] regs_q [2**segre_pkg::REG_ADDR_SIZE];

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        regs_q <= '{default: '0};
    end else if (we_i && waddr_i != '0) begin
        // x0 is never written, so it reads as zero
        regs_q[waddr_i] <= wdata_i;
    end
end

assign data_a_o = regs_q[raddr_a_i];
assign data_b_o = regs_q[raddr_b_i];

endmodule : segre_register_file

/* tb_segre_core.sv */
module tb_segre_core;
timeunit 1ns;
timeprecision 1ps;

localparam logic [31:0] BOOT_ADDR   = 32'h0000_0400;
localparam int          PROG_LEN    = 64;
localparam int          DATA_WORDS  = 64;
localparam int          TIMEOUT     = 100;
localparam logic [15:0] SEED        = 16'd32295;
// BEQ x0, x0, 0
localparam logic [31:0] SELF_BRANCH = 32'h0000_0063;

typedef enum int {
    K_LUI, K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_LW, K_SW, K_BEQ, K_BNE
} kind_e;

logic        clk;
logic        arst_n;
logic        mm_data_rdy;
logic [31:0] mm_rd_data;
logic [31:0] mm_wr_data;
logic [31:0] mm_addr;
logic [31:0] mm_wr_addr;
logic        mm_rd;
logic        mm_wr;

logic [15:0] lfsr_q;
kind_e       prog_kind [PROG_LEN];
logic [4:0]  prog_rd [PROG_LEN];
logic [4:0]  prog_rs1 [PROG_LEN];
logic [4:0]  prog_rs2 [PROG_LEN];
logic [31:0] prog_imm [PROG_LEN];
logic [31:0] imem [PROG_LEN];
logic [31:0] mem_data [DATA_WORDS];
// Reference model state
logic [31:0] ref_dmem [DATA_WORDS];
logic [31:0] ref_regs [32];
logic [31:0] ref_pc;

segre_core #(
    .BOOT_ADDR (BOOT_ADDR)
) i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .mm_data_rdy_i (mm_data_rdy),
    .mm_rd_data_i  (mm_rd_data),
    .mm_wr_data_o  (mm_wr_data),
    .mm_addr_o     (mm_addr),
    .mm_wr_addr_o  (mm_wr_addr),
    .mm_rd_o       (mm_rd),
    .mm_wr_o       (mm_wr)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        val    = {val[30:0], lfsr_q[0]};
    end
endtask

function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
endfunction

// RV32I encodings
function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd, rs1, rs2,
                                       input logic [31:0] imm);
    case (k)
        K_LUI:   return {imm[31:12], rd, 7'b0110111};
        K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
        K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
        K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
        K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
        K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
        K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
        K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
        K_BNE:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
        default: return 32'h0000_0013;
    endcase
endfunction

task automatic gen_program;
    logic [31:0] v;
    for (int i = 0; i < PROG_LEN; i++) begin
        rand_bits(4, v);
        prog_kind[i] = kind_e'(v % 11);
        rand_bits(3, v);
        prog_rd[i] = v[4:0];
        rand_bits(3, v);
        prog_rs1[i] = v[4:0];
        rand_bits(3, v);
        prog_rs2[i] = v[4:0];
        case (prog_kind[i])
            K_LUI: begin
                rand_bits(20, v);
                prog_imm[i] = {v[19:0], 12'b0};
            end
            K_ADDI: begin
                rand_bits(12, v);
                prog_imm[i] = {{20{v[11]}}, v[11:0]};
            end
            K_LW, K_SW: begin
                // Base x0 keeps the access inside the data region
                rand_bits(8, v);
                prog_imm[i] = {24'b0, v[7:0]};
                prog_rs1[i] = '0;
            end
            K_BEQ, K_BNE: begin
                rand_bits(3, v);
                prog_imm[i] = (v + 32'd1) << 2;
            end
            default: prog_imm[i] = '0;
        endcase
        imem[i] = encode(prog_kind[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
    end
endtask

task automatic init_memories;
    for (int i = 0; i < DATA_WORDS; i++) begin
        mem_data[i] = fill_word(32'(i * 4));
        ref_dmem[i] = fill_word(32'(i * 4));
    end
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
endtask

task automatic end_with_failure;
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on failure");
endtask

task automatic fail_value(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    end_with_failure();
endtask

task automatic wait_request(output logic is_wr, output logic [31:0] addr,
                            output logic [31:0] wdata);
    int   cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < TIMEOUT) begin
        @(posedge clk);
        found = mm_rd || mm_wr;
        cycles++;
    end
    is_wr = mm_wr;
    addr  = mm_wr ? mm_wr_addr : mm_addr;
    wdata = mm_wr_data;
    if (!found) begin
        $display("Timeout at %0t ns: the core stopped requesting main memory", $time);
        end_with_failure();
    end
endtask

// Answer after 0 to 3 wait cycles with a one-cycle rdy pulse
task automatic respond(input logic [31:0] rdata);
    logic [31:0] waits;
    rand_bits(2, waits);
    repeat (waits) @(posedge clk);
    mm_data_rdy <= 1'b1;
    mm_rd_data  <= rdata;
    @(posedge clk);
    mm_data_rdy <= 1'b0;
    mm_rd_data  <= '0;
endtask

task automatic check_data_access(input logic exp_wr, input logic [31:0] exp_addr,
                                 input logic [31:0] exp_data);
    logic        is_wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    wait_request(is_wr, addr, wdata);
    assert (is_wr == exp_wr && addr == exp_addr)
        else fail_value($sformatf("data access write=%0b at %h, expected write=%0b at %h",
                                  is_wr, addr, exp_wr, exp_addr));
    if (is_wr) begin
        assert (wdata == exp_data)
            else fail_value($sformatf("store data %h at %h, expected %h", wdata, addr, exp_data));
        mem_data[addr[7:2]] = wdata;
        respond('0);
    end else begin
        respond(mem_data[addr[7:2]]);
    end
endtask

task automatic execute_model(input int idx);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] daddr;
    logic [31:0] next_pc;
    logic        we;
    a       = ref_regs[prog_rs1[idx]];
    b       = ref_regs[prog_rs2[idx]];
    res     = '0;
    we      = 1'b1;
    next_pc = ref_pc + 32'd4;
    daddr   = (a + prog_imm[idx]) & 32'hFFFF_FFFC;
    case (prog_kind[idx])
        K_LUI:  res = prog_imm[idx];
        K_ADDI: res = a + prog_imm[idx];
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_LW: begin
            check_data_access(1'b0, daddr, '0);
            res = ref_dmem[daddr[7:2]];
        end
        K_SW: begin
            we = 1'b0;
            check_data_access(1'b1, daddr, b);
            ref_dmem[daddr[7:2]] = b;
        end
        K_BEQ: begin
            we = 1'b0;
            if (a == b) next_pc = ref_pc + prog_imm[idx];
        end
        default: begin
            we = 1'b0;
            if (a != b) next_pc = ref_pc + prog_imm[idx];
        end
    endcase
    if (we && prog_rd[idx] != '0) begin
        ref_regs[prog_rd[idx]] = res;
    end
    ref_pc = next_pc;
endtask

initial begin
    logic        is_wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    int          beyond;
    arst_n      <= 1'b0;
    mm_data_rdy <= 1'b0;
    mm_rd_data  <= '0;
    lfsr_q = SEED;
    gen_program();
    init_memories();
    ref_pc = BOOT_ADDR;
    beyond = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // Every request after a finished instruction must be the next fetch
    while (beyond < 2) begin
        wait_request(is_wr, addr, wdata);
        assert (!is_wr && addr == ref_pc)
            else fail_value($sformatf("fetch write=%0b at %h, expected read at %h",
                                      is_wr, addr, ref_pc));
        if (addr >= BOOT_ADDR && addr < BOOT_ADDR + 32'(4 * PROG_LEN)) begin
            respond(imem[(addr - BOOT_ADDR) >> 2]);
            execute_model(int'((addr - BOOT_ADDR) >> 2));
        end else begin
            // Past the program every word is a self-branch
            beyond++;
            respond(SELF_BRANCH);
        end
    end

    if (i_dut.i_segre_core_properties.fail_count == 0) begin
        $display("Finished with no errors");
        $finish;
    end else begin
        $display("The main-memory handshake properties failed %0d times",
                 i_dut.i_segre_core_properties.fail_count);
        end_with_failure();
    end
end

endmodule : tb_segre_core
